// ==== src/ld_mem_pkg.sv ====
// ------------------------------------------------------------
// Memory side constants of the ciphertext load engine
// Address and data widths, page geometry, burst length limits
// ------------------------------------------------------------

`default_nettype none

package ld_mem_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int MEM_ADDR_W       = 32;
  // Two 32-bit coefficient slots per word
  localparam int MEM_DATA_W       = 64;
  localparam int MEM_DATA_BYTES   = 8;
  localparam int MEM_DATA_BYTES_W = $clog2(MEM_DATA_BYTES);

  // ------------------------------------------------------------
  // Page geometry
  // ------------------------------------------------------------
  // A read burst never crosses a page
  localparam int PAGE_BYTES       = 64;
  localparam int PAGE_BYTES_W     = $clog2(PAGE_BYTES);
  localparam int PAGE_WORDS       = PAGE_BYTES / MEM_DATA_BYTES;

  // Burst length field, words minus one
  localparam int MEM_LEN_W        = 8;
  localparam int MEM_LEN_MAX      = 255;

endpackage

`default_nettype wire

// ==== src/ld_regf_pkg.sv ====
// ------------------------------------------------------------
// Register file side constants and command field widths
// ------------------------------------------------------------

`default_nettype none

package ld_regf_pkg;

  // Kept coefficient width after truncation
  localparam int MOD_Q_W      = 16;
  // Coefficient slot width in memory
  localparam int COEF_SLOT_W  = 32;
  // Coefficients per register file word
  localparam int REGF_COEF_NB = 2;

  // Command fields
  localparam int REGID_W      = 6;
  localparam int CID_W        = 8;

  // Word address inside one register
  localparam int REGF_WORD_W  = 6;

endpackage

`default_nettype wire

// ==== src/ld_fifo.sv ====
// ------------------------------------------------------------
// Valid/ready FIFO, circular buffer with a typed payload
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ld_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     s_rst_n,

  input  payload_t in_data,
  input  logic     in_vld,
  output logic     in_rdy,

  output payload_t out_data,
  output logic     out_vld,
  input  logic     out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_rdy   = (count != CNT_W'(DEPTH));
  assign out_vld  = (count != '0);
  assign push     = in_vld & in_rdy;
  assign pop      = out_vld & out_rdy;
  // Head entry straight from the storage registers
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/ld_cfg_regs.sv ====
// ------------------------------------------------------------
// Base and stride configuration registers
// Ciphertext start address from its index
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ld_cfg_regs
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
(
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  cfg_wr_vld,
  input  logic                  cfg_wr_sel,
  input  logic [MEM_ADDR_W-1:0] cfg_wr_data,

  input  logic [CID_W-1:0]      cid,
  output logic [MEM_ADDR_W-1:0] ct_start_addr
);

  logic [MEM_ADDR_W-1:0] base_addr;
  logic [MEM_ADDR_W-1:0] stride;

  // sel 0 writes the base, sel 1 the stride
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      base_addr <= '0;
      stride    <= '0;
    end else if (cfg_wr_vld) begin
      if (cfg_wr_sel) begin
        stride <= cfg_wr_data;
      end else begin
        base_addr <= cfg_wr_data;
      end
    end
  end

  assign ct_start_addr = base_addr + MEM_ADDR_W'(cid) * stride;

endmodule

`default_nettype wire

// ==== src/ld_rd_req.sv ====
// ------------------------------------------------------------
// Command queue and page bounded read burst generation
// Reception queue of reg ids awaiting their data
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ld_rd_req
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
#(
  parameter int WORD_PER_BLWE   = 10,
  parameter int INST_FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic [CID_W-1:0]      cmd_cid,
  input  logic [REGID_W-1:0]    cmd_reg_id,

  output logic [CID_W-1:0]      head_cid,
  input  logic [MEM_ADDR_W-1:0] ct_start_addr,

  output logic                  ar_vld,
  input  logic                  ar_rdy,
  output logic [MEM_ADDR_W-1:0] ar_addr,
  output logic [MEM_LEN_W-1:0]  ar_len,

  output logic                  rid_vld,
  input  logic                  rid_rdy,
  output logic [REGID_W-1:0]    rid_reg_id
);

  localparam int RCP_FIFO_DEPTH = 8;
  localparam int WCNT_W         = $clog2(WORD_PER_BLWE + 1);
  localparam int NB_W           = MEM_LEN_W + 1;

  typedef struct packed {
    logic [CID_W-1:0]   cid;
    logic [REGID_W-1:0] reg_id;
  } ld_cmd_t;

  ld_cmd_t               cmd_in;
  ld_cmd_t               q_cmd;
  logic                  q_vld;
  logic                  q_rdy;
  logic                  rcp_in_vld;
  logic                  rcp_in_rdy;

  logic                  first_burst;
  logic [WCNT_W-1:0]     words_rem;
  logic [MEM_ADDR_W-1:0] run_addr;
  logic [MEM_ADDR_W-1:0] burst_addr;
  logic [NB_W-1:0]       page_rem;
  logic [NB_W-1:0]       burst_nb;
  logic                  last_burst;
  logic                  stage_free;
  logic                  issue;

  assign cmd_in = '{cid: cmd_cid, reg_id: cmd_reg_id};

  ld_fifo #(
    .payload_t (ld_cmd_t),
    .DEPTH     (INST_FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (cmd_in),
    .in_vld   (cmd_vld),
    .in_rdy   (cmd_rdy),
    .out_data (q_cmd),
    .out_vld  (q_vld),
    .out_rdy  (q_rdy)
  );

  assign head_cid = q_cmd.cid;

  // ------------------------------------------------------------
  // Burst sizing
  // ------------------------------------------------------------
  // Start address only matters on the first burst of a command
  assign burst_addr = first_burst ? ct_start_addr : run_addr;
  assign page_rem   = NB_W'(PAGE_WORDS)
                    - NB_W'(burst_addr[PAGE_BYTES_W-1:MEM_DATA_BYTES_W]);
  assign burst_nb   = (32'(words_rem) < 32'(page_rem)) ? NB_W'(words_rem) : page_rem;
  assign last_burst = (32'(words_rem) == 32'(burst_nb));

  // Output stage takes a new burst when empty or draining
  assign stage_free = ~ar_vld | ar_rdy;
  // Reg id goes to the reception queue with the first burst
  assign rcp_in_vld = q_vld & first_burst & stage_free;
  assign issue      = q_vld & stage_free & (~first_burst | rcp_in_rdy);
  assign q_rdy      = issue & last_burst;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      first_burst <= 1'b1;
      words_rem   <= WCNT_W'(WORD_PER_BLWE);
      ar_vld      <= 1'b0;
    end else begin
      if (issue) begin
        first_burst <= last_burst;
        words_rem   <= last_burst ? WCNT_W'(WORD_PER_BLWE) : words_rem - WCNT_W'(burst_nb);
        ar_vld      <= 1'b1;
      end else if (ar_rdy) begin
        ar_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      run_addr <= burst_addr + (MEM_ADDR_W'(burst_nb) << MEM_DATA_BYTES_W);
      ar_addr  <= burst_addr;
      ar_len   <= MEM_LEN_W'(burst_nb - 1'b1);
    end
  end

  ld_fifo #(
    .payload_t (logic [REGID_W-1:0]),
    .DEPTH     (RCP_FIFO_DEPTH)
  ) i_rcp_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (q_cmd.reg_id),
    .in_vld   (rcp_in_vld),
    .in_rdy   (rcp_in_rdy),
    .out_data (rid_reg_id),
    .out_vld  (rid_vld),
    .out_rdy  (rid_rdy)
  );

endmodule

`default_nettype wire

// ==== src/ld_regf_wr.sv ====
// ------------------------------------------------------------
// Coefficient truncation and register file word buffering
// Chunked register file requests, acknowledge counting
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ld_regf_wr
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
#(
  parameter int WORD_PER_BLWE   = 10,
  parameter int WORD_THRESHOLD  = 4,
  parameter int DATA_FIFO_DEPTH = 16
) (
  input  logic                                 clk,
  input  logic                                 s_rst_n,

  input  logic                                 rid_vld,
  output logic                                 rid_rdy,
  input  logic [REGID_W-1:0]                   rid_reg_id,

  input  logic                                 r_vld,
  output logic                                 r_rdy,
  input  logic [MEM_DATA_W-1:0]                r_data,

  output logic                                 wr_req_vld,
  input  logic                                 wr_req_rdy,
  output logic [REGID_W-1:0]                   wr_req_reg_id,
  output logic [REGF_WORD_W-1:0]               wr_req_start_word,
  output logic [REGF_WORD_W-1:0]               wr_req_word_nb_m1,

  output logic                                 wr_data_vld,
  input  logic                                 wr_data_rdy,
  output logic [REGF_COEF_NB-1:0][MOD_Q_W-1:0] wr_data,

  input  logic                                 wr_ack,
  output logic                                 cmd_ack
);

  localparam int REQ_NB  = (WORD_PER_BLWE + WORD_THRESHOLD - 1) / WORD_THRESHOLD;
  localparam int REQ_W   = (REQ_NB > 1) ? $clog2(REQ_NB) : 1;
  localparam int LAST_NB = WORD_PER_BLWE - (REQ_NB - 1) * WORD_THRESHOLD;
  // Enough for every reg id that may still wait for its requests
  localparam int AVAIL_W = $clog2(WORD_PER_BLWE * 9 + DATA_FIFO_DEPTH + 1);

  typedef logic [REGF_COEF_NB-1:0][MOD_Q_W-1:0] regf_word_t;

  regf_word_t             in_word;
  logic                   push;
  logic [AVAIL_W-1:0]     avail_cnt;
  logic [AVAIL_W-1:0]     chunk_nb;
  logic [REQ_W-1:0]       chunk_cnt;
  logic [REGF_WORD_W-1:0] start_word;
  logic                   last_chunk;
  logic                   enough;
  logic                   req_free;
  logic                   issue;
  logic [REQ_W-1:0]       ack_cnt;
  logic                   last_ack;

  // ------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------
  // Keep the low MOD_Q_W bits of each slot
  always_comb begin
    for (int i = 0; i < REGF_COEF_NB; i++) begin
      in_word[i] = r_data[i*COEF_SLOT_W +: MOD_Q_W];
    end
  end

  ld_fifo #(
    .payload_t (regf_word_t),
    .DEPTH     (DATA_FIFO_DEPTH)
  ) i_data_fifo (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (in_word),
    .in_vld   (r_vld),
    .in_rdy   (r_rdy),
    .out_data (wr_data),
    .out_vld  (wr_data_vld),
    .out_rdy  (wr_data_rdy)
  );

  assign push = r_vld & r_rdy;

  // ------------------------------------------------------------
  // Request generation
  // ------------------------------------------------------------
  assign last_chunk = (chunk_cnt == REQ_W'(REQ_NB - 1));
  assign chunk_nb   = last_chunk ? AVAIL_W'(LAST_NB) : AVAIL_W'(WORD_THRESHOLD);
  assign enough     = (avail_cnt >= chunk_nb);
  assign req_free   = ~wr_req_vld | wr_req_rdy;
  assign issue      = rid_vld & enough & req_free;
  // Reg id leaves once its last chunk is requested
  assign rid_rdy    = issue & last_chunk;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_cnt  <= '0;
      chunk_cnt  <= '0;
      start_word <= '0;
      wr_req_vld <= 1'b0;
    end else begin
      avail_cnt <= avail_cnt + AVAIL_W'(push) - (issue ? chunk_nb : '0);
      if (issue) begin
        chunk_cnt  <= last_chunk ? '0 : chunk_cnt + 1'b1;
        start_word <= last_chunk ? '0 : start_word + REGF_WORD_W'(WORD_THRESHOLD);
        wr_req_vld <= 1'b1;
      end else if (wr_req_rdy) begin
        wr_req_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      wr_req_reg_id     <= rid_reg_id;
      wr_req_start_word <= start_word;
      wr_req_word_nb_m1 <= REGF_WORD_W'(chunk_nb - 1'b1);
    end
  end

  // ------------------------------------------------------------
  // Acknowledge
  // ------------------------------------------------------------
  // REQ_NB acks close one command
  assign last_ack = (ack_cnt == REQ_W'(REQ_NB - 1));

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ack_cnt <= '0;
      cmd_ack <= 1'b0;
    end else begin
      if (wr_ack) begin
        ack_cnt <= last_ack ? '0 : ack_cnt + 1'b1;
      end
      cmd_ack <= wr_ack & last_ack;
    end
  end

endmodule

`default_nettype wire

// ==== src/blwe_load.sv ====
// ------------------------------------------------------------
// Ciphertext load engine top level
// Configuration, read request and register file write blocks
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blwe_load
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
#(
  parameter int WORD_PER_BLWE   = 10,
  parameter int WORD_THRESHOLD  = 4,
  parameter int INST_FIFO_DEPTH = 4,
  parameter int DATA_FIFO_DEPTH = 16
) (
  input  logic                                 clk,
  input  logic                                 s_rst_n,

  input  logic                                 cfg_wr_vld,
  input  logic                                 cfg_wr_sel,
  input  logic [MEM_ADDR_W-1:0]                cfg_wr_data,

  input  logic                                 cmd_vld,
  output logic                                 cmd_rdy,
  input  logic [CID_W-1:0]                     cmd_cid,
  input  logic [REGID_W-1:0]                   cmd_reg_id,
  output logic                                 cmd_ack,

  output logic                                 ar_vld,
  input  logic                                 ar_rdy,
  output logic [MEM_ADDR_W-1:0]                ar_addr,
  output logic [MEM_LEN_W-1:0]                 ar_len,

  // Burst ends follow from the word count, r_last is informative
  input  logic                                 r_vld,
  output logic                                 r_rdy,
  input  logic [MEM_DATA_W-1:0]                r_data,
  input  logic                                 r_last,

  output logic                                 wr_req_vld,
  input  logic                                 wr_req_rdy,
  output logic [REGID_W-1:0]                   wr_req_reg_id,
  output logic [REGF_WORD_W-1:0]               wr_req_start_word,
  output logic [REGF_WORD_W-1:0]               wr_req_word_nb_m1,

  output logic                                 wr_data_vld,
  input  logic                                 wr_data_rdy,
  output logic [REGF_COEF_NB-1:0][MOD_Q_W-1:0] wr_data,

  input  logic                                 wr_ack
);

  logic [CID_W-1:0]      head_cid;
  logic [MEM_ADDR_W-1:0] ct_start_addr;
  logic                  rid_vld;
  logic                  rid_rdy;
  logic [REGID_W-1:0]    rid_reg_id;

  ld_cfg_regs i_ld_cfg_regs (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .cfg_wr_vld    (cfg_wr_vld),
    .cfg_wr_sel    (cfg_wr_sel),
    .cfg_wr_data   (cfg_wr_data),
    .cid           (head_cid),
    .ct_start_addr (ct_start_addr)
  );

  ld_rd_req #(
    .WORD_PER_BLWE   (WORD_PER_BLWE),
    .INST_FIFO_DEPTH (INST_FIFO_DEPTH)
  ) i_ld_rd_req (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .cmd_cid       (cmd_cid),
    .cmd_reg_id    (cmd_reg_id),
    .head_cid      (head_cid),
    .ct_start_addr (ct_start_addr),
    .ar_vld        (ar_vld),
    .ar_rdy        (ar_rdy),
    .ar_addr       (ar_addr),
    .ar_len        (ar_len),
    .rid_vld       (rid_vld),
    .rid_rdy       (rid_rdy),
    .rid_reg_id    (rid_reg_id)
  );

  ld_regf_wr #(
    .WORD_PER_BLWE   (WORD_PER_BLWE),
    .WORD_THRESHOLD  (WORD_THRESHOLD),
    .DATA_FIFO_DEPTH (DATA_FIFO_DEPTH)
  ) i_ld_regf_wr (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .rid_vld           (rid_vld),
    .rid_rdy           (rid_rdy),
    .rid_reg_id        (rid_reg_id),
    .r_vld             (r_vld),
    .r_rdy             (r_rdy),
    .r_data            (r_data),
    .wr_req_vld        (wr_req_vld),
    .wr_req_rdy        (wr_req_rdy),
    .wr_req_reg_id     (wr_req_reg_id),
    .wr_req_start_word (wr_req_start_word),
    .wr_req_word_nb_m1 (wr_req_word_nb_m1),
    .wr_data_vld       (wr_data_vld),
    .wr_data_rdy       (wr_data_rdy),
    .wr_data           (wr_data),
    .wr_ack            (wr_ack),
    .cmd_ack           (cmd_ack)
  );

endmodule

`default_nettype wire

// ==== tb/blwe_load_properties.sv ====
// ------------------------------------------------------------
// Concurrent assertions on the load engine ports
// Bound to the top level
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blwe_load_properties
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
(
  input logic                                 clk,
  input logic                                 s_rst_n,
  input logic                                 ar_vld,
  input logic                                 ar_rdy,
  input logic [MEM_ADDR_W-1:0]                ar_addr,
  input logic [MEM_LEN_W-1:0]                 ar_len,
  input logic                                 wr_req_vld,
  input logic                                 wr_req_rdy,
  input logic [REGF_WORD_W-1:0]               wr_req_start_word,
  input logic                                 wr_data_vld,
  input logic                                 wr_data_rdy,
  input logic [REGF_COEF_NB-1:0][MOD_Q_W-1:0] wr_data,
  input logic                                 cmd_ack
);

  a_len_max : assert property (@(posedge clk) disable iff (!s_rst_n)
    ar_vld |-> int'(ar_len) <= MEM_LEN_MAX)
    else $error("ar_len above the burst limit");

  // Last word of a burst stays inside the page
  a_page : assert property (@(posedge clk) disable iff (!s_rst_n)
    ar_vld |-> (32'(ar_addr[PAGE_BYTES_W-1:MEM_DATA_BYTES_W]) + 32'(ar_len))
               < 32'(PAGE_WORDS))
    else $error("read burst crosses a page");

  a_ar_hold : assert property (@(posedge clk) disable iff (!s_rst_n)
    ar_vld && !ar_rdy |=> ar_vld && $stable(ar_addr) && $stable(ar_len))
    else $error("ar_vld dropped or changed before ar_rdy");

  a_req_hold : assert property (@(posedge clk) disable iff (!s_rst_n)
    wr_req_vld && !wr_req_rdy |=> wr_req_vld && $stable(wr_req_start_word))
    else $error("wr_req_vld dropped or changed before wr_req_rdy");

  a_data_hold : assert property (@(posedge clk) disable iff (!s_rst_n)
    wr_data_vld && !wr_data_rdy |=> wr_data_vld && $stable(wr_data))
    else $error("wr_data_vld dropped or changed before wr_data_rdy");

  a_ack_pulse : assert property (@(posedge clk) disable iff (!s_rst_n)
    cmd_ack |=> !cmd_ack)
    else $error("cmd_ack high for two cycles");

endmodule

bind blwe_load blwe_load_properties i_blwe_load_properties (
  .clk               (clk),
  .s_rst_n           (s_rst_n),
  .ar_vld            (ar_vld),
  .ar_rdy            (ar_rdy),
  .ar_addr           (ar_addr),
  .ar_len            (ar_len),
  .wr_req_vld        (wr_req_vld),
  .wr_req_rdy        (wr_req_rdy),
  .wr_req_start_word (wr_req_start_word),
  .wr_data_vld       (wr_data_vld),
  .wr_data_rdy       (wr_data_rdy),
  .wr_data           (wr_data),
  .cmd_ack           (cmd_ack)
);

`default_nettype wire

// ==== tb/tb_blwe_load.sv ====
// ------------------------------------------------------------
// Testbench of the ciphertext load engine
// Clock, reset, memory and register file models
// Reference model, checker and watchdog
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_blwe_load
  import ld_mem_pkg::*;
  import ld_regf_pkg::*;
;

  localparam int WORD_PER_BLWE  = 10;
  localparam int WORD_THRESHOLD = 4;
  localparam int REQ_NB         = (WORD_PER_BLWE + WORD_THRESHOLD - 1) / WORD_THRESHOLD;
  localparam int NUM_CMDS       = 18;
  localparam logic [31:0] SEED  = 32'h21d3_6288;

  logic                    clk         = 1'b0;
  logic                    s_rst_n     = 1'b0;
  logic                    cfg_wr_vld  = 1'b0;
  logic                    cfg_wr_sel  = 1'b0;
  logic [MEM_ADDR_W-1:0]   cfg_wr_data = '0;
  logic                    cmd_vld     = 1'b0;
  logic [CID_W-1:0]        cmd_cid     = '0;
  logic [REGID_W-1:0]      cmd_reg_id  = '0;
  logic                    ar_rdy      = 1'b0;
  logic                    r_vld       = 1'b0;
  logic [MEM_DATA_W-1:0]   r_data      = '0;
  logic                    r_last      = 1'b0;
  logic                    wr_req_rdy  = 1'b0;
  logic                    wr_data_rdy = 1'b0;
  logic                    wr_ack      = 1'b0;
  logic                    cmd_rdy;
  logic                    cmd_ack;
  logic                    ar_vld;
  logic [MEM_ADDR_W-1:0]   ar_addr;
  logic [MEM_LEN_W-1:0]    ar_len;
  logic                    r_rdy;
  logic                    wr_req_vld;
  logic [REGID_W-1:0]      wr_req_reg_id;
  logic [REGF_WORD_W-1:0]  wr_req_start_word;
  logic [REGF_WORD_W-1:0]  wr_req_word_nb_m1;
  logic                    wr_data_vld;
  logic [REGF_COEF_NB-1:0][MOD_Q_W-1:0] wr_data;

  // Reference state and expected streams
  logic [MEM_ADDR_W-1:0]   cfg_base   = '0;
  logic [MEM_ADDR_W-1:0]   cfg_stride = '0;
  logic [39:0]             exp_bursts [$];
  logic [31:0]             exp_words  [$];
  logic [17:0]             exp_reqs   [$];
  logic [39:0]             exp_burst;
  logic [17:0]             exp_req;
  // Memory and register file model state
  logic [MEM_ADDR_W-1:0]   mem_addr_q [$];
  int                      mem_len_q  [$];
  int                      rf_req_q   [$];
  logic [MEM_ADDR_W-1:0]   beat_addr;
  logic                    r_hold;
  logic                    ack_exp    = 1'b0;
  int                      r_beat     = 0;
  int                      r_words    = 0;
  int                      req_words  = 0;
  int                      rf_words   = 0;
  int                      wr_ack_cnt = 0;
  int                      done_cmds  = 0;

  always #10 clk = ~clk;

  blwe_load #(
    .WORD_PER_BLWE   (WORD_PER_BLWE),
    .WORD_THRESHOLD  (WORD_THRESHOLD),
    .INST_FIFO_DEPTH (4),
    .DATA_FIFO_DEPTH (16)
  ) i_blwe_load (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .cfg_wr_vld        (cfg_wr_vld),
    .cfg_wr_sel        (cfg_wr_sel),
    .cfg_wr_data       (cfg_wr_data),
    .cmd_vld           (cmd_vld),
    .cmd_rdy           (cmd_rdy),
    .cmd_cid           (cmd_cid),
    .cmd_reg_id        (cmd_reg_id),
    .cmd_ack           (cmd_ack),
    .ar_vld            (ar_vld),
    .ar_rdy            (ar_rdy),
    .ar_addr           (ar_addr),
    .ar_len            (ar_len),
    .r_vld             (r_vld),
    .r_rdy             (r_rdy),
    .r_data            (r_data),
    .r_last            (r_last),
    .wr_req_vld        (wr_req_vld),
    .wr_req_rdy        (wr_req_rdy),
    .wr_req_reg_id     (wr_req_reg_id),
    .wr_req_start_word (wr_req_start_word),
    .wr_req_word_nb_m1 (wr_req_word_nb_m1),
    .wr_data_vld       (wr_data_vld),
    .wr_data_rdy       (wr_data_rdy),
    .wr_data           (wr_data),
    .wr_ack            (wr_ack)
  );

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // Upper slot is address plus one, lower slot the inverted address
  function automatic logic [31:0] regf_word(input logic [MEM_ADDR_W-1:0] addr);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = addr + 32'd1;
    lo = ~addr;
    return {hi[MOD_Q_W-1:0], lo[MOD_Q_W-1:0]};
  endfunction

  function automatic void add_expected(input logic [CID_W-1:0] cid,
                                       input logic [REGID_W-1:0] reg_id);
    logic [MEM_ADDR_W-1:0] addr;
    int                    left;
    int                    nb;
    int                    page_left;
    addr = cfg_base + 32'(cid) * cfg_stride;
    left = WORD_PER_BLWE;
    // Split at page boundaries
    while (left > 0) begin
      page_left = (PAGE_BYTES - int'(addr % 32'(PAGE_BYTES))) / MEM_DATA_BYTES;
      nb        = (left < page_left) ? left : page_left;
      exp_bursts.push_back({addr, 8'(nb - 1)});
      for (int i = 0; i < nb; i++) begin
        exp_words.push_back(regf_word(addr + 32'(i * MEM_DATA_BYTES)));
      end
      addr = addr + 32'(nb * MEM_DATA_BYTES);
      left = left - nb;
    end
    for (int c = 0; c < WORD_PER_BLWE; c += WORD_THRESHOLD) begin
      nb = (WORD_PER_BLWE - c < WORD_THRESHOLD) ? WORD_PER_BLWE - c : WORD_THRESHOLD;
      exp_reqs.push_back({reg_id, 6'(c), 6'(nb - 1)});
    end
  endfunction

  // ------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!s_rst_n) begin
      ar_rdy <= 1'b0;
      r_vld  <= 1'b0;
      r_last <= 1'b0;
    end else begin
      ar_rdy <= ($urandom_range(3) != 0);
      if (ar_vld && ar_rdy) begin
        if (exp_bursts.size() == 0) begin
          fail_run("Read burst issued with no command expecting it");
        end else begin
          exp_burst = exp_bursts.pop_front();
          check_value("ar_addr", 64'(ar_addr), 64'(exp_burst[39:8]));
          check_value("ar_len", 64'(ar_len), 64'(exp_burst[7:0]));
          mem_addr_q.push_back(ar_addr);
          mem_len_q.push_back(int'(ar_len) + 1);
        end
      end
      r_hold = r_vld && !r_rdy;
      if (r_vld && r_rdy) begin
        r_words <= r_words + 1;
        r_beat = r_beat + 1;
        if (r_beat == mem_len_q[0]) begin
          r_beat = 0;
          void'(mem_addr_q.pop_front());
          void'(mem_len_q.pop_front());
        end
      end
      // Data holds while the DUT stalls
      if (!r_hold) begin
        if (mem_addr_q.size() > 0 && $urandom_range(3) != 0) begin
          beat_addr = mem_addr_q[0] + 32'(r_beat * MEM_DATA_BYTES);
          r_vld  <= 1'b1;
          r_data <= {beat_addr + 32'd1, ~beat_addr};
          r_last <= (r_beat == mem_len_q[0] - 1);
        end else begin
          r_vld <= 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Register file model and cmd_ack checker
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!s_rst_n) begin
      wr_req_rdy  <= 1'b0;
      wr_data_rdy <= 1'b0;
      wr_ack      <= 1'b0;
    end else begin
      wr_req_rdy  <= ($urandom_range(3) != 0);
      wr_data_rdy <= ($urandom_range(2) != 0);
      wr_ack      <= 1'b0;
      check_value("cmd_ack", 64'(cmd_ack), 64'(ack_exp));
      // cmd_ack follows the last ack of each command by one cycle
      ack_exp = wr_ack && (wr_ack_cnt % REQ_NB == REQ_NB - 1);
      if (wr_ack) begin
        wr_ack_cnt = wr_ack_cnt + 1;
      end
      if (cmd_ack) begin
        done_cmds <= done_cmds + 1;
      end
      if (wr_req_vld && wr_req_rdy) begin
        if (exp_reqs.size() == 0) begin
          fail_run("Register file request with no command expecting it");
        end else begin
          exp_req = exp_reqs.pop_front();
          check_value("wr_req_reg_id", 64'(wr_req_reg_id), 64'(exp_req[17:12]));
          check_value("wr_req_start_word", 64'(wr_req_start_word), 64'(exp_req[11:6]));
          check_value("wr_req_word_nb_m1", 64'(wr_req_word_nb_m1), 64'(exp_req[5:0]));
          req_words = req_words + int'(wr_req_word_nb_m1) + 1;
          if (req_words > r_words) begin
            fail_run("Register file request raised before its words were buffered");
          end
          rf_req_q.push_back(int'(wr_req_word_nb_m1) + 1);
        end
      end
      if (wr_data_vld && wr_data_rdy) begin
        if (exp_words.size() == 0) begin
          fail_run("Register file data word with no command expecting it");
        end else begin
          check_value("wr_data", 64'(wr_data), 64'(exp_words.pop_front()));
          rf_words = rf_words + 1;
        end
      end
      // One ack per request once all its words arrived
      if (rf_req_q.size() > 0 && rf_words >= rf_req_q[0]) begin
        rf_words = rf_words - rf_req_q[0];
        void'(rf_req_q.pop_front());
        wr_ack <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic write_cfg(input logic sel, input logic [MEM_ADDR_W-1:0] data);
    cfg_wr_vld  <= 1'b1;
    cfg_wr_sel  <= sel;
    cfg_wr_data <= data;
    @(posedge clk);
    cfg_wr_vld <= 1'b0;
    if (sel) begin
      cfg_stride = data;
    end else begin
      cfg_base = data;
    end
  endtask

  task automatic send_cmd(input logic [CID_W-1:0] cid, input logic [REGID_W-1:0] reg_id);
    add_expected(cid, reg_id);
    cmd_vld    <= 1'b1;
    cmd_cid    <= cid;
    cmd_reg_id <= reg_id;
    @(posedge clk);
    while (!cmd_rdy) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_done(input int n);
    while (done_cmds < n) begin
      @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    s_rst_n <= 1'b1;
    @(posedge clk);
    // Aligned base, then an unaligned one
    write_cfg(1'b0, 32'h0);
    write_cfg(1'b1, 32'd128);
    send_cmd(8'd3, 6'd5);
    cmd_vld <= 1'b0;
    wait_done(1);
    write_cfg(1'b0, 32'h38);
    send_cmd(8'd0, 6'd9);
    cmd_vld <= 1'b0;
    wait_done(2);
    // Two batches of back to back commands
    write_cfg(1'b0, 32'h0000_1000);
    write_cfg(1'b1, 32'h0000_02a8);
    for (int i = 0; i < 8; i++) begin
      send_cmd(8'($urandom), 6'(i + 16));
    end
    cmd_vld <= 1'b0;
    wait_done(10);
    write_cfg(1'b0, 32'h0004_0018);
    write_cfg(1'b1, 32'h0000_0148);
    for (int i = 0; i < 8; i++) begin
      send_cmd(8'($urandom), 6'(i + 32));
    end
    cmd_vld <= 1'b0;
    wait_done(NUM_CMDS);
    repeat (20) @(posedge clk);
    if (exp_bursts.size() != 0 || exp_words.size() != 0 || exp_reqs.size() != 0
        || done_cmds != NUM_CMDS) begin
      fail_run("Run ended with expected bursts, words or acknowledges missing");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  // Budget of 4000 cycles per command
  initial begin
    repeat (NUM_CMDS * 4000) @(posedge clk);
    fail_run("Timeout: the commands did not complete within the cycle budget");
  end

endmodule

`default_nettype wire

// ==== blwe_load.f ====
src/ld_mem_pkg.sv
src/ld_regf_pkg.sv
src/ld_fifo.sv
src/ld_cfg_regs.sv
src/ld_rd_req.sv
src/ld_regf_wr.sv
src/blwe_load.sv
tb/blwe_load_properties.sv
tb/tb_blwe_load.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the load engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_blwe_load \
  -f blwe_load.f \
  --Mdir obj_dir \
  -o sim_blwe_load

# The log decides the result, so a stopped run still leaves its log
./obj_dir/sim_blwe_load > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
else
  exit 1
fi
